/* verilog/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and address widths
`define CORE_XLEN       32
`define CORE_IMEM_AW    10
`define CORE_REG_AW     5

// byte address of the first fetch after reset
`define CORE_RESET_PC   32'h0000_0000

// rv32i major opcodes handled by the decoder
`define CORE_OPC_OP     7'b0110011
`define CORE_OPC_OPIMM  7'b0010011
`define CORE_OPC_LUI    7'b0110111
`define CORE_OPC_BRANCH 7'b1100011
`define CORE_OPC_JAL    7'b1101111

`endif

/* verilog/core_pkg.sv */
`include "core_settings.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]    word_t;
    typedef logic [`CORE_XLEN-1:0]    addr_t;
    typedef logic [`CORE_IMEM_AW-1:0] imem_addr_t;
    typedef logic [`CORE_REG_AW-1:0]  reg_addr_t;

    // branch ops only compare, LINK returns pc + 4
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B,
        ALU_LINK,
        ALU_BEQ,
        ALU_BNE
    } alu_op_t;

    typedef enum logic [1:0] {
        ST_BOOT,
        ST_RUN,
        ST_REFILL
    } ctrl_state_t;

endpackage

/* verilog/exec_bus_if.sv */
interface exec_bus_if;

    logic                valid;
    core_pkg::alu_op_t   op;
    core_pkg::reg_addr_t rd;
    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    core_pkg::word_t     rs1_data;
    core_pkg::word_t     rs2_data;
    core_pkg::word_t     imm;
    core_pkg::addr_t     pc;
    logic                use_imm;
    logic                reg_write;

    modport dec (
        output valid, op, rd, rs1, rs2, rs1_data, rs2_data, imm, pc, use_imm, reg_write
    );

    // rs1/rs2 indices go along for forwarding in execute
    modport exe (
        input valid, op, rd, rs1, rs2, rs1_data, rs2_data, imm, pc, use_imm, reg_write
    );

endinterface

/* verilog/pc_counter.sv */
`include "core_settings.svh"

module pc_counter (
    input  logic                 clock_i,
    input  logic                 arst_n_i,
    input  logic                 redirect_i,
    input  core_pkg::addr_t      redirect_pc_i,
    output core_pkg::imem_addr_t addr_o,
    output core_pkg::addr_t      fetch_pc_o
);

    core_pkg::addr_t pc_q;
    core_pkg::addr_t pc_d;

    assign pc_d   = redirect_i ? redirect_pc_i : pc_q + core_pkg::addr_t'(4);
    assign addr_o = pc_q[`CORE_IMEM_AW+1:2];

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q       <= `CORE_RESET_PC;
            fetch_pc_o <= `CORE_RESET_PC;
        end else begin
            pc_q       <= pc_d;
            // memory answers one cycle later, keep pc in step with data_i
            fetch_pc_o <= pc_q;
        end
    end

    // redirect targets come from execute and must stay on word boundaries
    a_pc_aligned: assert property (
        @(posedge clock_i) disable iff (!arst_n_i)
        pc_q[1:0] == 2'b00
    );

endmodule

/* verilog/pipeline_ctrl.sv */
module pipeline_ctrl (
    input  logic clock_i,
    input  logic arst_n_i,
    input  logic redirect_i,
    output logic decode_valid_o
);

    core_pkg::ctrl_state_t state_q;
    core_pkg::ctrl_state_t state_d;

    always_comb begin
        case (state_q)
            core_pkg::ST_BOOT: begin
                state_d = core_pkg::ST_RUN;
            end
            default: begin
                // one dead slot after a redirect for the word already in flight
                state_d = redirect_i ? core_pkg::ST_REFILL : core_pkg::ST_RUN;
            end
        endcase
    end

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= core_pkg::ST_BOOT;
        end else begin
            state_q <= state_d;
        end
    end

    // the word in decode during a redirect is on the wrong path
    assign decode_valid_o = (state_q == core_pkg::ST_RUN) && !redirect_i;

    // nothing has reached execute yet while booting
    a_no_redirect_in_boot: assert property (
        @(posedge clock_i) disable iff (!arst_n_i)
        (state_q == core_pkg::ST_BOOT) |-> !redirect_i
    );

endmodule

/* verilog/decoder.sv */
`include "core_settings.svh"

module decoder (
    input  logic                clock_i,
    input  logic                arst_n_i,
    input  core_pkg::word_t     inst_i,
    input  core_pkg::addr_t     pc_i,
    input  logic                decode_valid_i,
    input  core_pkg::word_t     rs1_data_i,
    input  core_pkg::word_t     rs2_data_i,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    exec_bus_if.dec             bus
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    core_pkg::word_t   imm_i;
    core_pkg::word_t   imm_u;
    core_pkg::word_t   imm_b;
    core_pkg::word_t   imm_j;
    core_pkg::word_t   imm;
    core_pkg::alu_op_t op;
    logic              use_imm;
    logic              reg_write;

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // anything not listed falls out as a nop with no write and no branch
    always_comb begin
        op        = core_pkg::ALU_ADD;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        imm       = imm_i;
        case (opcode)
            `CORE_OPC_OPIMM: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  op = core_pkg::ALU_ADD;
                    3'b100:  op = core_pkg::ALU_XOR;
                    3'b110:  op = core_pkg::ALU_OR;
                    3'b111:  op = core_pkg::ALU_AND;
                    default: reg_write = 1'b0;
                endcase
            end
            `CORE_OPC_OP: begin
                reg_write = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: op = core_pkg::ALU_ADD;
                    10'b0100000_000: op = core_pkg::ALU_SUB;
                    10'b0000000_100: op = core_pkg::ALU_XOR;
                    10'b0000000_110: op = core_pkg::ALU_OR;
                    10'b0000000_111: op = core_pkg::ALU_AND;
                    default:         reg_write = 1'b0;
                endcase
            end
            `CORE_OPC_LUI: begin
                op        = core_pkg::ALU_PASS_B;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                imm       = imm_u;
            end
            `CORE_OPC_BRANCH: begin
                imm = imm_b;
                if (funct3 == 3'b000) begin
                    op = core_pkg::ALU_BEQ;
                end else if (funct3 == 3'b001) begin
                    op = core_pkg::ALU_BNE;
                end
            end
            `CORE_OPC_JAL: begin
                op        = core_pkg::ALU_LINK;
                reg_write = 1'b1;
                imm       = imm_j;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.valid     <= 1'b0;
            bus.reg_write <= 1'b0;
        end else begin
            bus.valid     <= decode_valid_i;
            bus.reg_write <= decode_valid_i && reg_write;
        end
    end

    always_ff @(posedge clock_i) begin
        bus.op       <= op;
        bus.rd       <= inst_i[11:7];
        bus.rs1      <= rs1_addr_o;
        bus.rs2      <= rs2_addr_o;
        bus.rs1_data <= rs1_data_i;
        bus.rs2_data <= rs2_data_i;
        bus.imm      <= imm;
        bus.pc       <= pc_i;
        bus.use_imm  <= use_imm;
    end

endmodule

/* verilog/regfile.sv */
`include "core_settings.svh"

module regfile (
    input  logic                clock_i,
    input  logic                arst_n_i,
    input  core_pkg::reg_addr_t rs1_addr_i,
    input  core_pkg::reg_addr_t rs2_addr_i,
    input  logic                we_i,
    input  core_pkg::reg_addr_t wr_addr_i,
    input  core_pkg::word_t     wr_data_i,
    output core_pkg::word_t     rs1_data_o,
    output core_pkg::word_t     rs2_data_o
);

    core_pkg::word_t regs [2**`CORE_REG_AW];

    // write-first, the retiring value is seen by decode in the same cycle
    function automatic core_pkg::word_t read_port(core_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (we_i && wr_addr_i == addr) begin
            return wr_data_i;
        end
        return regs[addr];
    endfunction

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**`CORE_REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // execute filters x0 before retire
    a_no_x0_write: assert property (
        @(posedge clock_i) disable iff (!arst_n_i)
        we_i |-> wr_addr_i != '0
    );

endmodule

/* verilog/execute.sv */
module execute (
    input  logic                clock_i,
    input  logic                arst_n_i,
    exec_bus_if.exe             bus,
    output logic                redirect_o,
    output core_pkg::addr_t     redirect_pc_o,
    output logic                retire_valid_o,
    output core_pkg::reg_addr_t retire_rd_o,
    output core_pkg::word_t     retire_data_o,
    output core_pkg::addr_t     retire_pc_o
);

    core_pkg::word_t op_a;
    core_pkg::word_t op_b_reg;
    core_pkg::word_t op_b;
    core_pkg::word_t result;
    logic            taken;

    // bypass from the retire register, older values come through the regfile
    function automatic core_pkg::word_t fwd(core_pkg::reg_addr_t idx, core_pkg::word_t data);
        if (retire_valid_o && retire_rd_o == idx) begin
            return retire_data_o;
        end
        return data;
    endfunction

    assign op_a     = fwd(bus.rs1, bus.rs1_data);
    assign op_b_reg = fwd(bus.rs2, bus.rs2_data);
    assign op_b     = bus.use_imm ? bus.imm : op_b_reg;

    always_comb begin
        result = op_a + op_b;
        taken  = 1'b0;
        case (bus.op)
            core_pkg::ALU_SUB:    result = op_a - op_b;
            core_pkg::ALU_AND:    result = op_a & op_b;
            core_pkg::ALU_OR:     result = op_a | op_b;
            core_pkg::ALU_XOR:    result = op_a ^ op_b;
            core_pkg::ALU_PASS_B: result = op_b;
            core_pkg::ALU_LINK: begin
                result = bus.pc + 32'd4;
                taken  = 1'b1;
            end
            core_pkg::ALU_BEQ:    taken = (op_a == op_b_reg);
            core_pkg::ALU_BNE:    taken = (op_a != op_b_reg);
            default: ;
        endcase
    end

    // predicted not-taken, so every taken branch redirects
    assign redirect_o    = bus.valid && taken;
    assign redirect_pc_o = bus.pc + bus.imm;

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= bus.valid && bus.reg_write && bus.rd != '0;
        end
    end

    always_ff @(posedge clock_i) begin
        if (bus.valid && bus.reg_write && bus.rd != '0) begin
            retire_rd_o   <= bus.rd;
            retire_data_o <= result;
            retire_pc_o   <= bus.pc;
        end
    end

    // the two wrong-path slots behind a redirect never reach execute
    a_redirect_squash: assert property (
        @(posedge clock_i) disable iff (!arst_n_i)
        redirect_o |-> bus.valid ##1 !bus.valid ##1 !bus.valid
    );

endmodule

/* verilog/core.sv */
module core (
    input  logic                 clock_i,
    input  logic                 arst_n_i,
    input  core_pkg::word_t      data_i,
    output core_pkg::imem_addr_t addr_o,
    output logic                 imem_sr_o,
    output logic                 retire_valid_o,
    output core_pkg::reg_addr_t  retire_rd_o,
    output core_pkg::word_t      retire_data_o,
    output core_pkg::addr_t      retire_pc_o
);

    core_pkg::addr_t     redirect_pc;
    core_pkg::addr_t     fetch_pc;
    logic                decode_valid;
    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::word_t     rs1_data;
    core_pkg::word_t     rs2_data;

    exec_bus_if u_exec_bus ();

    // imem_sr_o doubles as the internal redirect
    pc_counter u_pc_counter (
        .clock_i       (clock_i),
        .arst_n_i      (arst_n_i),
        .redirect_i    (imem_sr_o),
        .redirect_pc_i (redirect_pc),
        .addr_o        (addr_o),
        .fetch_pc_o    (fetch_pc)
    );

    pipeline_ctrl u_pipeline_ctrl (
        .clock_i        (clock_i),
        .arst_n_i       (arst_n_i),
        .redirect_i     (imem_sr_o),
        .decode_valid_o (decode_valid)
    );

    decoder u_decoder (
        .clock_i        (clock_i),
        .arst_n_i       (arst_n_i),
        .inst_i         (data_i),
        .pc_i           (fetch_pc),
        .decode_valid_i (decode_valid),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .bus            (u_exec_bus.dec)
    );

    regfile u_regfile (
        .clock_i    (clock_i),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .we_i       (retire_valid_o),
        .wr_addr_i  (retire_rd_o),
        .wr_data_i  (retire_data_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute u_execute (
        .clock_i        (clock_i),
        .arst_n_i       (arst_n_i),
        .bus            (u_exec_bus.exe),
        .redirect_o     (imem_sr_o),
        .redirect_pc_o  (redirect_pc),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o),
        .retire_pc_o    (retire_pc_o)
    );

endmodule

/* tests/core_tb.sv */
`include "core_settings.svh"

module core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS = 2**`CORE_IMEM_AW;

    typedef struct {
        core_pkg::addr_t     pc;
        core_pkg::reg_addr_t rd;
        core_pkg::word_t     data;
    } retire_t;

    logic                 clock = 1'b0;
    logic                 arst_n = 1'b0;
    core_pkg::word_t      data = '0;
    core_pkg::imem_addr_t addr;
    logic                 imem_sr;
    logic                 retire_valid;
    core_pkg::reg_addr_t  retire_rd;
    core_pkg::word_t      retire_data;
    core_pkg::addr_t      retire_pc;

    core_pkg::word_t mem [MEM_WORDS];
    retire_t         expected_q [$];
    // register values as the expected retires leave them
    core_pkg::word_t shadow_regs [2**`CORE_REG_AW];
    int              program_words = 0;
    int              cycle_count = 0;
    int              cycle_limit = 0;
    logic            out_of_reset_prev = 1'b0;
    core_pkg::word_t data_prev = '0;

    core u_core (
        .clock_i        (clock),
        .arst_n_i       (arst_n),
        .data_i         (data),
        .addr_o         (addr),
        .imem_sr_o      (imem_sr),
        .retire_valid_o (retire_valid),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data),
        .retire_pc_o    (retire_pc)
    );

    always #50 clock = ~clock;

    // instruction memory with one cycle of read latency
    always @(posedge clock) begin
        data <= mem[addr];
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("error: time %0t %s is %h, expected %h",
                                     $time, name, got, expected));
        end
    endtask

    // rv32i rule for jal, beq and bne on the current register values
    function automatic logic redirect_expected(input core_pkg::word_t inst);
        core_pkg::word_t a;
        core_pkg::word_t b;
        a = shadow_regs[inst[19:15]];
        b = shadow_regs[inst[24:20]];
        if (inst[6:0] == `CORE_OPC_JAL) begin
            return 1'b1;
        end else if (inst[6:0] == `CORE_OPC_BRANCH && inst[14:12] == 3'b000) begin
            return a == b;
        end else if (inst[6:0] == `CORE_OPC_BRANCH && inst[14:12] == 3'b001) begin
            return a != b;
        end
        return 1'b0;
    endfunction

    task automatic load_trace();
        int                   fd;
        int                   n;
        string                tag;
        string                rest;
        core_pkg::imem_addr_t waddr;
        core_pkg::word_t      word;
        core_pkg::addr_t      pc;
        core_pkg::reg_addr_t  rd;
        core_pkg::word_t      value;
        // unloaded words hold addi x0, x0, <word index>
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[core_pkg::imem_addr_t'(i)] =
                {2'b00, core_pkg::imem_addr_t'(i), 13'd0, `CORE_OPC_OPIMM};
        end
        for (int i = 0; i < 2**`CORE_REG_AW; i++) begin
            shadow_regs[i] = '0;
        end
        fd = $fopen("tests/core_trace.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open the trace file tests/core_trace.txt");
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "I") begin
                n = $fscanf(fd, "%h %h", waddr, word);
                check_value("trace I fields", 32'(n), 32'd2);
                mem[waddr] = word;
                program_words++;
            end else if (tag == "R") begin
                n = $fscanf(fd, "%h %d %h", pc, rd, value);
                check_value("trace R fields", 32'(n), 32'd3);
                expected_q.push_back('{pc, rd, value});
            end else if (tag == "#") begin
                n = $fgets(rest, fd);
            end else begin
                report_failure($sformatf("unknown record %s in the trace file", tag));
            end
        end
        $fclose(fd);
    endtask

    // outputs settle after the rising edge, so look at them mid cycle
    always @(negedge clock) begin
        retire_t head;
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            report_failure("timeout: expected retires not all seen");
        end else begin
            if (!arst_n || !out_of_reset_prev) begin
                check_value("retire_valid_o", 32'(retire_valid), 32'd0);
                check_value("imem_sr_o", 32'(imem_sr), 32'd0);
                check_value("addr_o", 32'(addr), 32'd0);
            end
            if (retire_valid) begin
                if (expected_q.size() == 0) begin
                    report_failure("a register write retired after the expected sequence");
                end else begin
                    head = expected_q.pop_front();
                    check_value("retire_pc_o", retire_pc, head.pc);
                    check_value("retire_rd_o", 32'(retire_rd), 32'(head.rd));
                    check_value("retire_data_o", retire_data, head.data);
                    shadow_regs[head.rd] = head.data;
                end
            end
            // the redirecting word came back on data_i one cycle earlier
            if (imem_sr) begin
                check_value("imem_sr_o",
                            32'(redirect_expected(data_prev)), 32'd1);
            end
            out_of_reset_prev = arst_n;
            data_prev = data;
        end
    end

    initial begin
        load_trace();
        cycle_limit = 16 + 4 * (program_words + expected_q.size()) + 40;
        repeat (16) @(posedge clock);
        arst_n <= 1'b1;
        while (expected_q.size() != 0) begin
            @(posedge clock);
        end
        // the program parks on a jal to itself
        repeat (20) @(posedge clock);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* files.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/exec_bus_if.sv
verilog/pc_counter.sv
verilog/pipeline_ctrl.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/execute.sv
verilog/core.sv
tests/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verilog/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the simulator printed the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* tests/core_trace.txt */
# I <word address hex> <instruction hex>
# R <retire pc hex> <rd decimal> <rd data hex>
I 000 00500093
I 001 00708113
I 002 002081b3
I 003 40118233
I 004 0ff24293
I 005 12345337
I 006 005363b3
I 007 0f03f413
I 008 00829663
I 009 00100513
I 00a 00200593
I 00b 00208463
I 00c 00308013
I 00d 05506613
I 00e 00c006ef
I 00f 00300713
I 010 00400793
I 011 00c68833
I 012 0000006f
R 00000000 1 00000005
R 00000004 2 0000000c
R 00000008 3 00000011
R 0000000c 4 0000000c
R 00000010 5 000000f3
R 00000014 6 12345000
R 00000018 7 123450f3
R 0000001c 8 000000f0
R 00000034 12 00000055
R 00000038 13 0000003c
R 00000044 16 00000091
